// File: source/tcp_consts.svh
`ifndef TCP_CONSTS_SVH
`define TCP_CONSTS_SVH

// idle cycles before a forced ack
`define TCP_ACK_TIMEOUT 125000

// initial sequence numbers
`define TCP_SERVER_ISN 32'hfeadabba
`define TCP_CLIENT_ISN 32'habbadead

`define TCP_WIN_SIZE 10 // advertised window

// header lengths in bytes, no options
`define TCP_HDR_BYTES  20
`define IPV4_HDR_BYTES 20

// outgoing flag words
`define TCP_FLAGS_SYN     9'h002
`define TCP_FLAGS_SYN_ACK 9'h012
`define TCP_FLAGS_ACK     9'h010
`define TCP_FLAGS_PSH_ACK 9'h018
`define TCP_FLAGS_FIN_ACK 9'h011

`endif

// File: source/tcp_pkg.sv
`default_nettype none

package tcp_pkg;

  // connection states
  typedef enum logic [2:0] {
    closed_s,
    listen_s,
    syn_sent_s,
    syn_received_s,
    established_s,
    send_fin_s,
    send_ack_s,
    last_ack_s
  } tcp_state_e;

  // how the connection is being torn down
  typedef enum logic [1:0] {
    close_active,
    close_passive,
    close_reset
  } close_kind_e;

  // flags field, built as a word on transmit and tested per bit on receive
  typedef union packed {
    logic [8:0] word;
    struct packed {
      logic ns;
      logic cwr;
      logic ece;
      logic urg;
      logic ack;
      logic psh;
      logic rst;
      logic syn;
      logic fin;
    } bits;
  } tcp_flags_u;

endpackage

`default_nettype wire

// File: source/tcp_rx_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_rx_filter (
  input  logic                clk,
  input  logic                tcp_rst,
  input  logic [15:0]         loc_port,
  input  logic                rx_hdr_v,
  input  logic [31:0]         rx_src_ip,
  input  logic [15:0]         rx_src_port,
  input  logic [15:0]         rx_dst_port,
  input  logic [31:0]         rx_seq,
  input  logic [31:0]         rx_ack,
  input  logic [8:0]          rx_flags,
  input  logic [15:0]         rx_payload_len,
  input  logic                rx_v,
  input  logic [7:0]          rx_d,
  input  logic [15:0]         tcb_port,
  input  logic [31:0]         tcb_loc_ack,
  input  logic                rx_accept,
  output logic                seg_v,
  output logic [31:0]         seg_src_ip,
  output logic [15:0]         seg_src_port,
  output logic [31:0]         seg_seq,
  output logic [31:0]         seg_ack,
  output tcp_pkg::tcp_flags_u seg_flags,
  output logic [15:0]         seg_len,
  output logic                port_match,
  output logic                peer_match,
  output logic                in_order,
  output logic                vout,
  output logic [7:0]          dout
);

  logic       dst_hit;
  logic       rx_v_q;
  logic [7:0] rx_d_q;

  assign dst_hit = (rx_dst_port == loc_port);

  ////////////////////////////////////////
  // header stage
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      seg_v <= 1'b0;
    end else begin
      seg_v <= rx_hdr_v;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_hdr_v) begin
      seg_src_ip   <= rx_src_ip;
      seg_src_port <= rx_src_port;
      seg_seq      <= rx_seq;
      seg_ack      <= rx_ack;
      seg_flags    <= rx_flags;
      seg_len      <= rx_payload_len;
      port_match   <= dst_hit;
      peer_match   <= dst_hit && (rx_src_port == tcb_port); // same remote as the tcb
      in_order     <= (rx_seq == tcb_loc_ack);
    end
  end

  ////////////////////////////////////////
  // payload delay line
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      rx_v_q <= 1'b0;
      vout   <= 1'b0;
    end else begin
      rx_v_q <= rx_v;
      vout   <= rx_v_q && rx_accept; // drop bytes of rejected segments
    end
  end

  always_ff @(posedge clk) begin
    rx_d_q <= rx_d;
    dout   <= rx_d_q;
  end

endmodule

`default_nettype wire

// File: source/tcp_conn_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_consts.svh"

module tcp_conn_fsm #(
  parameter int unsigned ACK_TIMEOUT = `TCP_ACK_TIMEOUT
) (
  input  logic                clk,
  input  logic                tcp_rst,
  input  logic [15:0]         loc_port,
  input  logic                listen,
  input  logic                connect,
  input  logic                force_fin,
  input  logic [31:0]         rem_ip,
  input  logic [15:0]         rem_port,
  input  logic                seg_v,
  input  logic [31:0]         seg_src_ip,
  input  logic [15:0]         seg_src_port,
  input  logic [31:0]         seg_seq,
  input  logic [31:0]         seg_ack,
  input  tcp_pkg::tcp_flags_u seg_flags,
  input  logic [15:0]         seg_len,
  input  logic                port_match,
  input  logic                peer_match,
  input  logic                in_order,
  input  logic                queue_pend,
  input  logic [31:0]         queue_seq,
  input  logic [15:0]         queue_len,
  input  logic [31:0]         queue_cs,
  input  logic                queue_flushed,
  input  logic                tx_busy,
  input  logic                tx_pend,
  output logic [15:0]         tcb_port,
  output logic [31:0]         tcb_loc_ack,
  output logic                rx_accept,
  output logic                connected,
  output logic                flush_queue,
  output logic                seg_req,
  output logic [31:0]         req_dst_ip,
  output logic [15:0]         req_dst_port,
  output logic [31:0]         req_seq,
  output logic [31:0]         req_ack,
  output tcp_pkg::tcp_flags_u req_flags,
  output logic [15:0]         req_ip_len,
  output logic [15:0]         req_payload_len,
  output logic [31:0]         req_payload_cs
);

  import tcp_pkg::*;

  localparam int TW = $clog2(ACK_TIMEOUT + 1);
  localparam logic [TW-1:0] TIMER_MAX = TW'(ACK_TIMEOUT);
  localparam logic [15:0] HDR_LEN = 16'(`IPV4_HDR_BYTES + `TCP_HDR_BYTES);

  tcp_state_e    state;
  close_kind_e   close_kind;
  logic          is_server;
  logic [31:0]   tcb_ip;
  logic [31:0]   tcb_loc_seq;
  logic [TW-1:0] ack_timer;
  logic          ack_due;
  logic          accept_q;
  logic          sent;
  logic          fin_acked;
  logic          tx_free;
  logic          port_ok;
  logic          peer_seg;
  logic          req_go;
  tcp_flags_u    nxt_flags;
  logic [31:0]   nxt_ip;
  logic [15:0]   nxt_port;
  logic [31:0]   nxt_seq;
  logic [31:0]   nxt_ack;
  logic [15:0]   nxt_len;
  logic [31:0]   nxt_cs;

  assign tx_free   = !seg_req && !tx_pend && !tx_busy;
  assign port_ok   = (loc_port != 16'd0); // port 0 is reserved
  assign peer_seg  = seg_v && peer_match;
  assign connected = (state == established_s);
  assign rx_accept = accept_q && connected;

  ////////////////////////////////////////
  // segment selection
  ////////////////////////////////////////
  always_comb begin
    req_go         = 1'b0;
    nxt_flags.word = `TCP_FLAGS_ACK;
    nxt_ip         = tcb_ip;
    nxt_port       = tcb_port;
    nxt_seq        = tcb_loc_seq;
    nxt_ack        = tcb_loc_ack;
    nxt_len        = '0;
    nxt_cs         = '0;
    case (state)
      closed_s: if (port_ok && !listen && connect && tx_free) begin
        req_go         = 1'b1;
        nxt_flags.word = `TCP_FLAGS_SYN;
        nxt_ip         = rem_ip; // tcb is filled in the same cycle
        nxt_port       = rem_port;
        nxt_seq        = `TCP_CLIENT_ISN;
        nxt_ack        = '0;
      end
      listen_s: if (listen && seg_v && port_match && seg_flags.bits.syn && tx_free) begin
        req_go         = 1'b1;
        nxt_flags.word = `TCP_FLAGS_SYN_ACK;
        nxt_ip         = seg_src_ip;
        nxt_port       = seg_src_port;
        nxt_seq        = `TCP_SERVER_ISN;
        nxt_ack        = seg_seq + 32'd1;
      end
      syn_sent_s: if (peer_seg && seg_flags.bits.syn && seg_flags.bits.ack && tx_free) begin
        req_go  = 1'b1;
        nxt_seq = tcb_loc_seq + 32'd1;
        nxt_ack = seg_seq + 32'd1;
      end
      established_s: begin
        if (queue_pend && tx_free) begin
          req_go         = 1'b1;
          nxt_flags.word = `TCP_FLAGS_PSH_ACK;
          nxt_seq        = queue_seq;
          nxt_len        = queue_len;
          nxt_cs         = queue_cs;
        end else if (ack_due && tx_free) begin
          req_go = 1'b1; // pure ack
        end
      end
      send_fin_s: if (!sent && tx_free) begin
        req_go         = 1'b1;
        nxt_flags.word = `TCP_FLAGS_FIN_ACK;
      end
      send_ack_s: if (tx_free) begin
        req_go  = 1'b1;
        nxt_ack = tcb_loc_ack + 32'd1; // covers the remote fin
      end
      last_ack_s: if (!sent && tx_free) begin
        req_go         = 1'b1;
        nxt_flags.word = `TCP_FLAGS_FIN_ACK;
        nxt_ack        = tcb_loc_ack + 32'd1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_go) begin
      req_dst_ip      <= nxt_ip;
      req_dst_port    <= nxt_port;
      req_seq         <= nxt_seq;
      req_ack         <= nxt_ack;
      req_flags       <= nxt_flags;
      req_ip_len      <= HDR_LEN + nxt_len;
      req_payload_len <= nxt_len;
      req_payload_cs  <= nxt_cs;
    end
  end

  ////////////////////////////////////////
  // state and tcb
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      state       <= closed_s;
      close_kind  <= close_active;
      is_server   <= 1'b0;
      seg_req     <= 1'b0;
      flush_queue <= 1'b0;
      ack_timer   <= TIMER_MAX;
      ack_due     <= 1'b0;
      accept_q    <= 1'b0;
      sent        <= 1'b0;
      fin_acked   <= 1'b0;
    end else begin
      seg_req <= req_go;
      case (state)
        closed_s: begin
          sent      <= 1'b0;
          fin_acked <= 1'b0;
          accept_q  <= 1'b0;
          ack_due   <= 1'b0;
          ack_timer <= TIMER_MAX; // armed only by received data
          if (port_ok && listen) begin
            is_server <= 1'b1;
            state     <= listen_s;
          end else if (req_go) begin
            is_server   <= 1'b0;
            tcb_ip      <= rem_ip;
            tcb_port    <= rem_port;
            tcb_loc_seq <= `TCP_CLIENT_ISN;
            tcb_loc_ack <= '0; // remote seq not known yet
            state       <= syn_sent_s;
          end
        end
        listen_s: begin
          if (!listen) begin
            state <= closed_s;
          end else if (req_go) begin
            tcb_ip      <= seg_src_ip;
            tcb_port    <= seg_src_port;
            tcb_loc_seq <= `TCP_SERVER_ISN;
            tcb_loc_ack <= seg_seq + 32'd1;
            state       <= syn_received_s;
          end
        end
        syn_sent_s: begin
          if (!connect) begin
            state <= closed_s;
          end else if (req_go) begin
            tcb_loc_seq <= tcb_loc_seq + 32'd1;
            tcb_loc_ack <= seg_seq + 32'd1;
            state       <= established_s;
          end
        end
        syn_received_s: begin
          if (!listen) begin
            state <= closed_s;
          end else if (peer_seg && seg_flags.bits.ack && in_order) begin
            tcb_loc_seq <= seg_ack;
            state       <= established_s;
          end
        end
        established_s: begin
          // receive side
          if (peer_seg) accept_q <= in_order;
          if (peer_seg && in_order) tcb_loc_ack <= tcb_loc_ack + 32'(seg_len);
          if (peer_seg && in_order && (seg_len != 16'd0)) begin
            ack_timer <= '0;
          end else if (ack_timer != TIMER_MAX) begin
            ack_timer <= ack_timer + 1'b1; // saturates, one ack per gap
          end
          if (ack_timer == TIMER_MAX - 1'b1) begin
            ack_due <= 1'b1;
          end else if (req_go) begin
            ack_due <= 1'b0; // any outgoing segment carries the ack
          end
          if (req_go && queue_pend) tcb_loc_seq <= queue_seq + 32'(queue_len);
          // close detection, then wait for the queue flush
          if (!flush_queue) begin
            if (force_fin || (is_server ? !listen : !connect)) begin
              flush_queue <= 1'b1;
              close_kind  <= close_active;
            end else if (peer_seg && seg_flags.bits.fin) begin
              flush_queue <= 1'b1;
              close_kind  <= close_passive;
            end else if (peer_seg && seg_flags.bits.rst) begin
              flush_queue <= 1'b1;
              close_kind  <= close_reset;
            end
          end else if (queue_flushed) begin
            flush_queue <= 1'b0;
            case (close_kind)
              close_active:  state <= send_fin_s;
              close_passive: state <= send_ack_s;
              default:       state <= closed_s; // rst, nothing to send
            endcase
          end
        end
        send_fin_s: begin
          if (req_go) begin
            sent        <= 1'b1;
            tcb_loc_seq <= tcb_loc_seq + 32'd1; // fin takes one seq
          end
          if (sent && peer_seg) begin
            if (seg_flags.bits.fin && fin_acked) begin
              sent  <= 1'b0;
              state <= send_ack_s;
            end else if (seg_flags.bits.ack) begin
              fin_acked <= 1'b1;
            end
          end
        end
        send_ack_s: begin
          if (req_go) begin
            sent  <= 1'b0;
            state <= last_ack_s;
          end
        end
        last_ack_s: begin
          if (req_go) sent <= 1'b1;
          if (sent && peer_seg && seg_flags.bits.ack) state <= closed_s;
        end
        default: state <= closed_s;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/tcp_tx_builder.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_builder (
  input  logic                clk,
  input  logic                tcp_rst,
  input  logic [15:0]         loc_port,
  input  logic                seg_req,
  input  logic [31:0]         req_dst_ip,
  input  logic [15:0]         req_dst_port,
  input  logic [31:0]         req_seq,
  input  logic [31:0]         req_ack,
  input  tcp_pkg::tcp_flags_u req_flags,
  input  logic [15:0]         req_ip_len,
  input  logic [15:0]         req_payload_len,
  input  logic [31:0]         req_payload_cs,
  input  logic                tx_busy,
  output logic                tx_pend,
  output logic                tx_hdr_v,
  output logic [31:0]         tx_dst_ip,
  output logic [15:0]         tx_src_port,
  output logic [15:0]         tx_dst_port,
  output logic [31:0]         tx_seq,
  output logic [31:0]         tx_ack,
  output logic [8:0]          tx_flags,
  output logic [15:0]         tx_ip_len,
  output logic [15:0]         tx_payload_len,
  output logic [31:0]         tx_payload_cs
);

  ////////////////////////////////////////
  // one-entry header buffer
  ////////////////////////////////////////
  // tx_pend covers the tx_hdr_v cycle too, so the fsm can't
  // queue a second header right behind the first
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      tx_pend  <= 1'b0;
      tx_hdr_v <= 1'b0;
    end else if (seg_req) begin
      tx_pend  <= 1'b1;
      tx_hdr_v <= !tx_busy; // straight through when the ip layer is idle
    end else if (tx_hdr_v) begin
      tx_pend  <= 1'b0;
      tx_hdr_v <= 1'b0;
    end else begin
      tx_hdr_v <= tx_pend && !tx_busy; // first cycle after busy drops
    end
  end

  // header fields held until the next request
  always_ff @(posedge clk) begin
    if (seg_req) begin
      tx_dst_ip      <= req_dst_ip;
      tx_src_port    <= loc_port;
      tx_dst_port    <= req_dst_port;
      tx_seq         <= req_seq;
      tx_ack         <= req_ack;
      tx_flags       <= req_flags;
      tx_ip_len      <= req_ip_len;
      tx_payload_len <= req_payload_len;
      tx_payload_cs  <= req_payload_cs;
    end
  end

endmodule

`default_nettype wire

// File: source/tcp_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_consts.svh"

module tcp_endpoint #(
  parameter int unsigned ACK_TIMEOUT = `TCP_ACK_TIMEOUT
) (
  input  logic        clk,
  input  logic        tcp_rst,
  input  logic [15:0] loc_port,
  input  logic        listen,
  input  logic        connect,
  input  logic        force_fin,
  input  logic [31:0] rem_ip,
  input  logic [15:0] rem_port,
  output logic        connected,
  // parsed receive headers and payload
  input  logic        rx_hdr_v,
  input  logic [31:0] rx_src_ip,
  input  logic [15:0] rx_src_port,
  input  logic [15:0] rx_dst_port,
  input  logic [31:0] rx_seq,
  input  logic [31:0] rx_ack,
  input  logic [8:0]  rx_flags,
  input  logic [15:0] rx_payload_len,
  input  logic        rx_v,
  input  logic [7:0]  rx_d,
  output logic        vout,
  output logic [7:0]  dout,
  // headers to the ip layer
  input  logic        tx_busy,
  output logic        tx_hdr_v,
  output logic [31:0] tx_dst_ip,
  output logic [15:0] tx_src_port,
  output logic [15:0] tx_dst_port,
  output logic [31:0] tx_seq,
  output logic [31:0] tx_ack,
  output logic [8:0]  tx_flags,
  output logic [15:0] tx_ip_len,
  output logic [15:0] tx_payload_len,
  output logic [31:0] tx_payload_cs,
  // transmit queue
  input  logic        queue_pend,
  input  logic [31:0] queue_seq,
  input  logic [15:0] queue_len,
  input  logic [31:0] queue_cs,
  input  logic        queue_flushed,
  output logic        flush_queue
);

  import tcp_pkg::*;

  // filter to fsm
  logic        seg_v;
  logic [31:0] seg_src_ip;
  logic [15:0] seg_src_port;
  logic [31:0] seg_seq;
  logic [31:0] seg_ack;
  tcp_flags_u  seg_flags;
  logic [15:0] seg_len;
  logic        port_match;
  logic        peer_match;
  logic        in_order;
  // fsm back to filter
  logic [15:0] tcb_port;
  logic [31:0] tcb_loc_ack;
  logic        rx_accept;
  // fsm to builder
  logic        seg_req;
  logic [31:0] req_dst_ip;
  logic [15:0] req_dst_port;
  logic [31:0] req_seq;
  logic [31:0] req_ack;
  tcp_flags_u  req_flags;
  logic [15:0] req_ip_len;
  logic [15:0] req_payload_len;
  logic [31:0] req_payload_cs;
  logic        tx_pend;

  tcp_rx_filter u_rx_filter (.*);

  tcp_conn_fsm #(
    .ACK_TIMEOUT(ACK_TIMEOUT)
  ) u_conn_fsm (.*);

  tcp_tx_builder u_tx_builder (.*);

endmodule

`default_nettype wire

// File: test/tcp_endpoint_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_endpoint_properties (
  input logic                 clk,
  input logic                 tcp_rst,
  input logic                 tx_hdr_v,
  input logic                 tx_busy,
  input logic                 vout,
  input logic                 connected,
  input logic                 flush_queue,
  input logic                 queue_flushed,
  input tcp_pkg::tcp_state_e  state,
  input tcp_pkg::close_kind_e close_kind
);

  import tcp_pkg::*;

  ////////////////////////////////////////
  // transmit strobe
  ////////////////////////////////////////
  a_hdr_pulse: assert property (@(posedge clk) disable iff (tcp_rst)
    tx_hdr_v |=> !tx_hdr_v)
    else $error("tx_hdr_v high two cycles in a row");

  a_hdr_busy: assert property (@(posedge clk) disable iff (tcp_rst)
    tx_busy |-> !tx_hdr_v)
    else $error("tx_hdr_v issued while the ip layer is busy");

  ////////////////////////////////////////
  // receive and close
  ////////////////////////////////////////
  a_vout_conn: assert property (@(posedge clk) disable iff (tcp_rst)
    !connected |-> !vout)
    else $error("payload byte out while not connected");

  a_flush_closed: assert property (@(posedge clk) disable iff (tcp_rst)
    (!connected && state == closed_s) |-> !flush_queue)
    else $error("flush request in the closed state");

  // rst close goes straight back to closed
  a_reset_close: assert property (@(posedge clk) disable iff (tcp_rst)
    (flush_queue && queue_flushed && close_kind == close_reset) |=> state == closed_s)
    else $error("reset close did not return to closed");

endmodule

bind tcp_endpoint tcp_endpoint_properties u_props (
  .clk          (clk),
  .tcp_rst      (tcp_rst),
  .tx_hdr_v     (tx_hdr_v),
  .tx_busy      (tx_busy),
  .vout         (vout),
  .connected    (connected),
  .flush_queue  (flush_queue),
  .queue_flushed(queue_flushed),
  .state        (u_conn_fsm.state),
  .close_kind   (u_conn_fsm.close_kind)
);

`default_nettype wire

// File: test/tcp_endpoint_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcp_consts.svh"

module tcp_endpoint_tb;

  localparam logic [15:0] LOC_PORT = 16'd5000;
  localparam int          TIMEOUT  = 500; // cycles per wait
  localparam int          HDR_LEN  = `IPV4_HDR_BYTES + `TCP_HDR_BYTES;

  logic        clk;
  logic        tcp_rst;
  logic [15:0] loc_port;
  logic        listen;
  logic        connect;
  logic        force_fin;
  logic [31:0] rem_ip;
  logic [15:0] rem_port;
  logic        connected;
  logic        rx_hdr_v;
  logic [31:0] rx_src_ip;
  logic [15:0] rx_src_port;
  logic [15:0] rx_dst_port;
  logic [31:0] rx_seq;
  logic [31:0] rx_ack;
  logic [8:0]  rx_flags;
  logic [15:0] rx_payload_len;
  logic        rx_v;
  logic [7:0]  rx_d;
  logic        vout;
  logic [7:0]  dout;
  logic        tx_busy;
  logic        tx_hdr_v;
  logic [31:0] tx_dst_ip;
  logic [15:0] tx_src_port;
  logic [15:0] tx_dst_port;
  logic [31:0] tx_seq;
  logic [31:0] tx_ack;
  logic [8:0]  tx_flags;
  logic [15:0] tx_ip_len;
  logic [15:0] tx_payload_len;
  logic [31:0] tx_payload_cs;
  logic        queue_pend;
  logic [31:0] queue_seq;
  logic [15:0] queue_len;
  logic [31:0] queue_cs;
  logic        queue_flushed;
  logic        flush_queue;

  // remote peer view of the connection
  string       test_name;
  logic [31:0] peer_ip;
  logic [15:0] peer_port;
  logic [31:0] peer_seq; // next remote seq the endpoint should ack
  logic [31:0] loc_seq;  // next local seq expected from the endpoint

  tcp_endpoint #(
    .ACK_TIMEOUT(64)
  ) u_dut (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s in %s", why, test_name);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1; // drive and sample just after the edge
  endtask

  task automatic send_segment(input logic [31:0] seq, input logic [31:0] ack,
                              input logic [8:0] flags, input logic [15:0] len);
    rx_hdr_v       = 1'b1;
    rx_src_ip      = peer_ip;
    rx_src_port    = peer_port;
    rx_dst_port    = LOC_PORT;
    rx_seq         = seq;
    rx_ack         = ack;
    rx_flags       = flags;
    rx_payload_len = len;
    next_cycle();
    rx_hdr_v = 1'b0;
  endtask

  task automatic wait_tx(output int cycles);
    cycles = 0;
    do begin
      next_cycle();
      cycles++;
      if (cycles > TIMEOUT) abort_run("no tcp header sent before the timeout");
    end while (!tx_hdr_v);
  endtask

  task automatic check_hdr(input logic [8:0] flags, input logic [31:0] seq,
                           input logic [31:0] ack);
    check_value("flags", 32'(flags), 32'(tx_flags));
    check_value("seq", seq, tx_seq);
    check_value("ack", ack, tx_ack);
    check_value("src port", 32'(LOC_PORT), 32'(tx_src_port));
    check_value("dst port", 32'(peer_port), 32'(tx_dst_port));
  endtask

  task automatic wait_connected(input logic level);
    int n;
    n = 0;
    while (connected !== level) begin
      if (n == TIMEOUT) abort_run("connected did not reach the expected level");
      next_cycle();
      n++;
    end
  endtask

  // answers the flush request once it shows up
  task automatic finish_flush();
    int n;
    n = 0;
    while (flush_queue !== 1'b1) begin
      if (n == TIMEOUT) abort_run("flush_queue was never raised");
      next_cycle();
      n++;
    end
    queue_flushed = 1'b1;
    next_cycle();
    queue_flushed = 1'b0;
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      next_cycle();
      check_value("unexpected tx_hdr_v", 32'd0, 32'(tx_hdr_v));
    end
  endtask

  // payload bytes show up two cycles late when accepted
  task automatic stream_bytes(input int n, input logic accepted);
    logic [7:0] data [0:15];
    int i;
    for (i = 0; i < n; i++) data[i] = 8'($urandom);
    for (i = 0; i <= n; i++) begin
      rx_v = (i < n);
      rx_d = (i < n) ? data[i] : 8'h00;
      next_cycle();
      if (accepted && i >= 1) begin
        check_value("vout", 32'd1, 32'(vout));
        check_value("dout", 32'(data[i-1]), 32'(dout));
      end else begin
        check_value("vout", 32'd0, 32'(vout));
      end
    end
    rx_v = 1'b0;
    next_cycle();
    check_value("vout after payload", 32'd0, 32'(vout));
    next_cycle();
    check_value("vout idle", 32'd0, 32'(vout));
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_passive_open();
    int cyc;
    test_name = "passive_open";
    peer_ip   = $urandom;
    peer_port = 16'(1024 + $urandom % 4000);
    peer_seq  = $urandom;
    listen    = 1'b1;
    next_cycle();
    next_cycle();
    send_segment(peer_seq, 32'd0, `TCP_FLAGS_SYN, 16'd0);
    wait_tx(cyc);
    check_value("syn-ack latency", 32'd3, 32'(cyc + 1));
    check_hdr(`TCP_FLAGS_SYN_ACK, `TCP_SERVER_ISN, peer_seq + 32'd1);
    check_value("dst ip", peer_ip, tx_dst_ip);
    check_value("ip len", 32'(HDR_LEN), 32'(tx_ip_len));
    peer_seq = peer_seq + 32'd1;
    loc_seq  = `TCP_SERVER_ISN + 32'd1;
    send_segment(peer_seq, loc_seq, `TCP_FLAGS_ACK, 16'd0);
    wait_connected(1'b1);
  endtask

  task automatic test_receive();
    int cyc;
    int n;
    test_name = "receive";
    n = 4 + int'($urandom % 5);
    send_segment(peer_seq, loc_seq, `TCP_FLAGS_PSH_ACK, 16'(n));
    next_cycle();
    next_cycle();
    stream_bytes(n, 1'b1);
    peer_seq = peer_seq + 32'(n);
    // out-of-order payload must be dropped
    send_segment(peer_seq + 32'd100, loc_seq, `TCP_FLAGS_PSH_ACK, 16'd4);
    next_cycle();
    next_cycle();
    stream_bytes(4, 1'b0);
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_ACK, loc_seq, peer_seq);
    expect_quiet(3 * 64); // one ack per idle gap
  endtask

  task automatic test_queue_tx();
    int cyc;
    logic [15:0] len;
    logic [31:0] cs;
    test_name  = "queue_tx";
    len        = 16'(1 + $urandom % 512);
    cs         = $urandom;
    queue_pend = 1'b1;
    queue_seq  = loc_seq;
    queue_len  = len;
    queue_cs   = cs;
    next_cycle();
    queue_pend = 1'b0;
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_PSH_ACK, loc_seq, peer_seq);
    check_value("ip len", 32'(HDR_LEN) + 32'(len), 32'(tx_ip_len));
    check_value("payload len", 32'(len), 32'(tx_payload_len));
    check_value("payload cs", cs, tx_payload_cs);
    loc_seq = loc_seq + 32'(len);
    next_cycle();
    next_cycle();
    // busy rises right after the request is taken by the builder
    len        = 16'(1 + $urandom % 512);
    cs         = $urandom;
    queue_pend = 1'b1;
    queue_seq  = loc_seq;
    queue_len  = len;
    queue_cs   = cs;
    next_cycle();
    queue_pend = 1'b0;
    tx_busy    = 1'b1;
    expect_quiet(10);
    tx_busy = 1'b0;
    next_cycle();
    check_value("tx_hdr_v after busy", 32'd1, 32'(tx_hdr_v));
    check_hdr(`TCP_FLAGS_PSH_ACK, loc_seq, peer_seq);
    check_value("payload len", 32'(len), 32'(tx_payload_len));
    check_value("payload cs", cs, tx_payload_cs);
    loc_seq = loc_seq + 32'(len);
    expect_quiet(5);
  endtask

  task automatic test_active_close();
    int cyc;
    test_name = "active_close";
    listen    = 1'b0;
    finish_flush();
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_FIN_ACK, loc_seq, peer_seq);
    loc_seq = loc_seq + 32'd1;
    send_segment(peer_seq, loc_seq, `TCP_FLAGS_ACK, 16'd0);
    expect_quiet(5);
    send_segment(peer_seq, loc_seq, `TCP_FLAGS_FIN_ACK, 16'd0);
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_ACK, loc_seq, peer_seq + 32'd1);
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_FIN_ACK, loc_seq, peer_seq + 32'd1);
    peer_seq = peer_seq + 32'd1;
    send_segment(peer_seq, loc_seq + 32'd1, `TCP_FLAGS_ACK, 16'd0);
    expect_quiet(20);
    check_value("connected", 32'd0, 32'(connected));
  endtask

  task automatic test_active_open();
    int cyc;
    test_name = "active_open";
    peer_ip   = $urandom;
    peer_port = 16'(6000 + $urandom % 4000);
    rem_ip    = peer_ip;
    rem_port  = peer_port;
    connect   = 1'b1;
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_SYN, `TCP_CLIENT_ISN, 32'd0);
    check_value("dst ip", peer_ip, tx_dst_ip);
    loc_seq  = `TCP_CLIENT_ISN + 32'd1;
    peer_seq = $urandom;
    send_segment(peer_seq, loc_seq, `TCP_FLAGS_SYN_ACK, 16'd0);
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_ACK, loc_seq, peer_seq + 32'd1);
    peer_seq = peer_seq + 32'd1;
    wait_connected(1'b1);
    // remote closes
    test_name = "passive_close";
    send_segment(peer_seq, loc_seq, `TCP_FLAGS_FIN_ACK, 16'd0);
    finish_flush();
    connect = 1'b0;
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_ACK, loc_seq, peer_seq + 32'd1);
    wait_tx(cyc);
    check_hdr(`TCP_FLAGS_FIN_ACK, loc_seq, peer_seq + 32'd1);
    peer_seq = peer_seq + 32'd1;
    send_segment(peer_seq, loc_seq + 32'd1, `TCP_FLAGS_ACK, 16'd0);
    expect_quiet(20);
    check_value("connected", 32'd0, 32'(connected));
  endtask

  task automatic test_reset_close();
    test_passive_open();
    test_name = "reset_close";
    send_segment(peer_seq, loc_seq, 9'h004, 16'd0);
    finish_flush();
    check_value("connected", 32'd0, 32'(connected));
    expect_quiet(20);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(32'h8bdc));
    test_name      = "reset";
    tcp_rst        = 1'b1;
    loc_port       = LOC_PORT;
    listen         = 1'b0;
    connect        = 1'b0;
    force_fin      = 1'b0;
    rem_ip         = 32'd0;
    rem_port       = 16'd0;
    rx_hdr_v       = 1'b0;
    rx_src_ip      = 32'd0;
    rx_src_port    = 16'd0;
    rx_dst_port    = 16'd0;
    rx_seq         = 32'd0;
    rx_ack         = 32'd0;
    rx_flags       = 9'd0;
    rx_payload_len = 16'd0;
    rx_v           = 1'b0;
    rx_d           = 8'd0;
    tx_busy        = 1'b0;
    queue_pend     = 1'b0;
    queue_seq      = 32'd0;
    queue_len      = 16'd0;
    queue_cs       = 32'd0;
    queue_flushed  = 1'b0;
    repeat (5) next_cycle();
    tcp_rst = 1'b0;
    next_cycle();

    test_passive_open();
    test_receive();
    test_queue_tx();
    test_active_close();
    test_active_open();
    test_reset_close();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/tcp_pkg.sv
source/tcp_rx_filter.sv
source/tcp_conn_fsm.sv
source/tcp_tx_builder.sv
source/tcp_endpoint.sv
test/tcp_endpoint_properties.sv
test/tcp_endpoint_tb.sv

// File: run.sh
#!/bin/sh
# build and run the tcp endpoint testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module tcp_endpoint_tb -o tcp_endpoint_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tcp_endpoint_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
